// ==== files.f ====
common/kbd_pkg.sv
ps2_rx/ps2_frame_rx.sv
kbd_fifo/kbd_gray_fifo.sv
source/kbd_controller.sv
bench/kbd_props.sv
bench/kbd_tb.sv

// ==== Bender.yml ====
package:
  name: kbd_controller

sources:
  # shared constants first
  - common/kbd_pkg.sv
  # receiver and FIFO before the top level
  - ps2_rx/ps2_frame_rx.sv
  - kbd_fifo/kbd_gray_fifo.sv
  - source/kbd_controller.sv
  # simulation only
  - target: test
    files:
      - bench/kbd_props.sv
      - bench/kbd_tb.sv

// ==== bench/kbd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_tb
  import kbd_pkg::*;
();

  localparam int CORE_HALF    = 50;
  // core cycles per kbd_clk half period
  localparam int KBD_HALF_CYC = 4;
  // idle core cycles after each frame
  localparam int FRAME_GAP    = 8;
  localparam int RANDOM_CODES = 20;

  logic       core_clk;
  logic       rst_n;
  logic       kbd_clk;
  logic       kbd_data;
  logic       scanf_en;
  logic       read_en;
  logic       data_ready;
  logic [7:0] data_out;
  logic       frame_error;

  // codes the FIFO should hand out, oldest first
  logic [7:0] exp_q[$];
  logic [7:0] exp_head;
  int         exp_cnt;

  // levels that the checkers hold the DUT to
  logic hold_empty;
  logic hold_no_error;

  logic [31:0] lfsr;
  int          depth;
  int          cycle_cnt;
  int          cycle_limit;
  int          err_cnt;
  int          test_errs_start;
  int          test_cnt;
  int          fail_cnt;

  kbd_controller i_dut (
    .kbd_clk     (kbd_clk),
    .kbd_data    (kbd_data),
    .core_clk    (core_clk),
    .rst_n       (rst_n),
    .scanf_en    (scanf_en),
    .read_en     (read_en),
    .data_ready  (data_ready),
    .data_out    (data_out),
    .frame_error (frame_error)
  );

  always #(CORE_HALF) core_clk = ~core_clk;

  // every pop delivers the oldest code still expected
  assert property (@(posedge core_clk) disable iff (!rst_n)
    (read_en && data_ready && exp_cnt > 0) |-> (data_out == exp_head))
  else begin
    $display("FAIL time %0t data_out got %02h expected %02h",
             $time, $sampled(data_out), $sampled(exp_head));
    err_cnt++;
  end

  assert property (@(posedge core_clk) disable iff (!rst_n)
    hold_empty |-> !data_ready)
  else begin
    $display("FAIL time %0t data_ready got %b expected 0", $time, $sampled(data_ready));
    err_cnt++;
  end

  assert property (@(posedge core_clk) disable iff (!rst_n)
    hold_no_error |-> !frame_error)
  else begin
    $display("FAIL time %0t frame_error got %b expected 0", $time, $sampled(frame_error));
    err_cnt++;
  end

  // a stuck handshake ends the run here
  always @(posedge core_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("run stalled, %0d core cycles passed and the tests did not finish", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int total_errors();
    return err_cnt + i_dut.i_props.fail_cnt;
  endfunction

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : 8'h00;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge core_clk);
  endtask

  task automatic expect_bit(input string name, input logic got, input logic want);
    assert (got === want) else begin
      $display("FAIL time %0t %s got %b expected %b", $time, name, got, want);
      err_cnt++;
    end
  endtask

  // keyboard model
  // start bit, data lsb first, parity, stop bit
  // data changes while kbd_clk is high
  task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                            input logic bad_stop);
    logic [10:0] bits;
    // parity bit makes the count of ones odd
    bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      kbd_data = bits[i];
      wait_cycles(KBD_HALF_CYC);
      kbd_clk = 1'b0;
      wait_cycles(KBD_HALF_CYC);
      kbd_clk = 1'b1;
    end
    kbd_data = 1'b1;
    wait_cycles(FRAME_GAP);
  endtask

  // make code, break prefix, then the same code again
  task automatic send_release(input logic [7:0] c);
    if (scanf_en && exp_q.size() < depth) begin
      exp_q.push_back(c);
      refresh_head();
    end
    send_frame(c, 1'b0, 1'b0);
    send_frame(KBD_BREAK_CODE, 1'b0, 1'b0);
    send_frame(c, 1'b0, 1'b0);
  endtask

  task automatic read_one();
    int waited;
    waited = 0;
    while (!data_ready && waited < 20) begin
      wait_cycles(1);
      waited++;
    end
    assert (data_ready) else begin
      $display("time %0t: data_ready did not rise for an expected code", $time);
      err_cnt++;
    end
    if (data_ready) begin
      read_en = 1'b1;
      wait_cycles(1);
      read_en = 1'b0;
    end
    // the code is dropped from the model either way so the test moves on
    void'(exp_q.pop_front());
    refresh_head();
  endtask

  // read everything expected, then nothing more may be offered
  task automatic drain();
    while (exp_q.size() > 0) begin
      read_one();
    end
    wait_cycles(6);
    expect_bit("data_ready", data_ready, 1'b0);
  endtask

  task automatic begin_test();
    test_errs_start = total_errors();
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - test_errs_start;
    test_cnt++;
    if (errs == 0) begin
      $display("test %0d %s passed", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s failed with %0d errors", test_cnt, name, errs);
    end
  endtask

  initial begin
    logic [7:0] pick;
    logic [7:0] rnd_code;
    core_clk      = 1'b0;
    rst_n         = 1'b1;
    kbd_clk       = 1'b1;
    kbd_data      = 1'b1;
    scanf_en      = 1'b0;
    read_en       = 1'b0;
    hold_empty    = 1'b0;
    hold_no_error = 1'b0;
    lfsr          = 32'hf0de_8de8;
    cycle_cnt     = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    fail_cnt      = 0;
    refresh_head();
    depth = 1 << i_dut.FIFO_ADDR_W;
    // 19 frames in the directed tests, 3 per release in overflow and random traffic
    cycle_limit = (19 + 3 * (depth + 2) + 3 * RANDOM_CODES) * 88 * 2 + 2000;

    // kbd_clk stays idle high across the reset
    @(negedge core_clk);
    rst_n = 1'b0;
    repeat (4) @(negedge core_clk);
    rst_n = 1'b1;

    begin_test();
    hold_empty    = 1'b1;
    hold_no_error = 1'b1;
    wait_cycles(40);
    hold_empty = 1'b0;
    end_test("reset");

    begin_test();
    scanf_en   = 1'b1;
    hold_empty = 1'b1;
    send_frame(8'h1C, 1'b0, 1'b0);
    wait_cycles(8);
    hold_empty = 1'b0;
    send_release(8'h1C);
    drain();
    end_test("release capture");

    // the enable reaches kbd_clk during the make frame
    begin_test();
    scanf_en   = 1'b0;
    hold_empty = 1'b1;
    send_release(8'h32);
    send_release(8'h24);
    hold_empty = 1'b0;
    scanf_en   = 1'b1;
    send_release(8'h24);
    drain();
    end_test("enable gating");

    // a damaged frame also drops the pending prefix
    begin_test();
    hold_empty    = 1'b1;
    hold_no_error = 1'b0;
    send_frame(KBD_BREAK_CODE, 1'b0, 1'b0);
    send_frame(8'h2B, 1'b1, 1'b0);
    expect_bit("frame_error", frame_error, 1'b1);
    send_frame(8'h2B, 1'b0, 1'b0);
    expect_bit("frame_error", frame_error, 1'b0);
    send_frame(KBD_BREAK_CODE, 1'b0, 1'b0);
    send_frame(8'h34, 1'b0, 1'b1);
    expect_bit("frame_error", frame_error, 1'b1);
    send_frame(8'h34, 1'b0, 1'b0);
    expect_bit("frame_error", frame_error, 1'b0);
    hold_empty = 1'b0;
    end_test("frame errors");

    // the last two releases find the FIFO full
    begin_test();
    for (int i = 0; i < depth + 2; i++) begin
      send_release(8'h10 + 8'(i));
    end
    drain();
    end_test("overflow");

    begin_test();
    for (int n = 0; n < RANDOM_CODES; n++) begin
      take_bits(1, pick);
      // a full model forces a read so that no release is lost
      if (exp_q.size() > 0 && (pick[0] || exp_q.size() == depth)) begin
        read_one();
      end
      take_bits(8, rnd_code);
      while (rnd_code == KBD_BREAK_CODE) begin
        take_bits(8, rnd_code);
      end
      send_release(rnd_code);
    end
    drain();
    end_test("random traffic");

    wait_cycles(10);
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             test_cnt, test_cnt - fail_cnt, fail_cnt, total_errors());
    if (total_errors() == 0 && fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/kbd_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_props
  import kbd_pkg::*;
(
  input logic                     core_clk,
  input logic                     kbd_clk,
  input logic                     rst_n,
  input logic                     scanf_en,
  input logic                     data_ready,
  input logic [KBD_DATA_BITS-1:0] data_out,
  input logic                     frame_error,
  input logic                     wr_en
);

  // number of property failures so far
  int fail_cnt = 0;

  // nothing is offered to the core while reset is held
  assert property (@(posedge core_clk) !rst_n |-> (!data_ready && !frame_error))
  else begin
    fail_cnt++;
    $error("data_ready or frame_error is high while rst_n is low");
  end

  // the oldest code is fully defined whenever it is offered
  assert property (@(posedge core_clk) disable iff (!rst_n)
    data_ready |-> !$isunknown(data_out))
  else begin
    fail_cnt++;
    $error("data_out has unknown bits while data_ready is high");
  end

  // a FIFO write needs scanf_en high two kbd_clk edges before it
  assert property (@(posedge kbd_clk) disable iff (!rst_n)
    wr_en |-> $past(scanf_en, 2))
  else begin
    fail_cnt++;
    $error("FIFO write strobe while the synchronized scanf_en is low");
  end

endmodule

bind kbd_controller kbd_props i_props (
  .core_clk    (core_clk),
  .kbd_clk     (kbd_clk),
  .rst_n       (rst_n),
  .scanf_en    (scanf_en),
  .data_ready  (data_ready),
  .data_out    (data_out),
  .frame_error (frame_error),
  .wr_en       (wr_en)
);

`default_nettype wire

// ==== source/kbd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_controller
  import kbd_pkg::*;
#(
  parameter int FIFO_ADDR_W = 3
) (
  // ps/2 side
  input  logic                     kbd_clk,
  input  logic                     kbd_data,
  // core side
  input  logic                     core_clk,
  input  logic                     rst_n,
  input  logic                     scanf_en,
  input  logic                     read_en,
  output logic                     data_ready,
  output logic [KBD_DATA_BITS-1:0] data_out,
  output logic                     frame_error
);

  // receiver results, kbd_clk domain
  logic [KBD_DATA_BITS-1:0] code;
  logic                     code_valid;
  logic                     frame_error_kc;

  // sw enable brought over to the keyboard clock
  logic scanf_en_kq1;
  logic scanf_en_kc;

  // first stage of the error synchronizer
  logic frame_error_cq1;

  // FIFO write strobe
  logic wr_en;

  // kbd_clk only runs during frames, so the enable settles within a frame or two
  always_ff @(posedge kbd_clk or negedge rst_n) begin
    if (!rst_n) begin
      scanf_en_kq1 <= 1'b0;
      scanf_en_kc  <= 1'b0;
    end else begin
      scanf_en_kq1 <= scanf_en;
      scanf_en_kc  <= scanf_en_kq1;
    end
  end

  // error level into the core domain
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_error_cq1 <= 1'b0;
      frame_error     <= 1'b0;
    end else begin
      frame_error_cq1 <= frame_error_kc;
      frame_error     <= frame_error_cq1;
    end
  end

  // released keys are kept only while software asks for them
  assign wr_en = code_valid && scanf_en_kc;

  ps2_frame_rx i_frame_rx (
    .kbd_clk        (kbd_clk),
    .rst_n          (rst_n),
    .kbd_data       (kbd_data),
    .code           (code),
    .code_valid     (code_valid),
    .frame_error_kc (frame_error_kc)
  );

  // write lands on the rising kbd_clk edge after the stop bit
  kbd_gray_fifo #(
    .FIFO_ADDR_W (FIFO_ADDR_W)
  ) i_fifo (
    .kbd_clk    (kbd_clk),
    .core_clk   (core_clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_data    (code),
    .read_en    (read_en),
    .data_ready (data_ready),
    .data_out   (data_out)
  );

endmodule

`default_nettype wire

// ==== kbd_fifo/kbd_gray_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_gray_fifo
  import kbd_pkg::*;
#(
  parameter int FIFO_ADDR_W = 3
) (
  input  logic                     kbd_clk,
  input  logic                     core_clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  logic [KBD_DATA_BITS-1:0] wr_data,
  input  logic                     read_en,
  output logic                     data_ready,
  output logic [KBD_DATA_BITS-1:0] data_out
);

  localparam int DEPTH = 1 << FIFO_ADDR_W;

  // one extra pointer bit tells full from empty
  localparam int PTR_W = FIFO_ADDR_W + 1;

  // gray pointer of a full FIFO differs from the read pointer in the two top bits
  localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (FIFO_ADDR_W - 1);

  function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // storage, written in the kbd_clk domain and read in the core domain
  logic [KBD_DATA_BITS-1:0] mem [DEPTH];

  // write side, kbd_clk domain
  logic [PTR_W-1:0] wr_bin;
  logic [PTR_W-1:0] wr_bin_next;
  logic [PTR_W-1:0] wr_gray;
  logic [PTR_W-1:0] rd_gray_kq1;
  logic [PTR_W-1:0] rd_gray_kq2;
  logic             full;
  logic             wr_accept;

  // read side, core_clk domain
  logic [PTR_W-1:0] rd_bin;
  logic [PTR_W-1:0] rd_bin_next;
  logic [PTR_W-1:0] rd_gray;
  logic [PTR_W-1:0] wr_gray_cq1;
  logic [PTR_W-1:0] wr_gray_cq2;
  logic             empty;
  logic             pop;

  // full uses a stale read pointer, so it may report full a little too long
  assign full        = (wr_gray == (rd_gray_kq2 ^ FULL_MASK));
  // the keyboard cannot wait, a write into a full FIFO is lost
  assign wr_accept   = wr_en && !full;
  assign wr_bin_next = wr_bin + PTR_W'(1);

  // write pointer and read pointer synchronizer
  always_ff @(posedge kbd_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_kq1 <= '0;
      rd_gray_kq2 <= '0;
    end else begin
      rd_gray_kq1 <= rd_gray;
      rd_gray_kq2 <= rd_gray_kq1;
      if (wr_accept) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= bin2gray(wr_bin_next);
      end
    end
  end

  always_ff @(posedge kbd_clk) begin
    if (wr_accept) begin
      mem[wr_bin[FIFO_ADDR_W-1:0]] <= wr_data;
    end
  end

  // empty uses a stale write pointer, a new code shows up two flops later
  assign empty       = (rd_gray == wr_gray_cq2);
  assign data_ready  = !empty;
  // read_en without data is ignored
  assign pop         = read_en && data_ready;
  assign rd_bin_next = rd_bin + PTR_W'(1);

  // read pointer and write pointer synchronizer
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_cq1 <= '0;
      wr_gray_cq2 <= '0;
    end else begin
      wr_gray_cq1 <= wr_gray;
      wr_gray_cq2 <= wr_gray_cq1;
      if (pop) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= bin2gray(rd_bin_next);
      end
    end
  end

  // first word fall through
  // the oldest code is on data_out while data_ready is high
  // the slot cannot be rewritten before the pop reaches the write side
  assign data_out = mem[rd_bin[FIFO_ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== ps2_rx/ps2_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
  import kbd_pkg::*;
(
  input  logic                     kbd_clk,
  input  logic                     rst_n,
  input  logic                     kbd_data,
  output logic [KBD_DATA_BITS-1:0] code,
  output logic                     code_valid,
  output logic                     frame_error_kc
);

  // the keyboard drives data while kbd_clk is high
  // so every bit is taken on the falling edge of kbd_clk

  // frame bit counter
  // 0 means idle and waiting for a start bit
  // 1 to 10 count the bits already taken in the current frame
  logic [3:0] bit_cnt;

  // bits taken so far, newest on top
  // after ten bits the start bit sits at position 0
  logic [KBD_FRAME_BITS-2:0] shift_q;

  // whole frame as seen on the stop bit edge
  logic [KBD_FRAME_BITS-1:0] frame_w;
  logic [KBD_DATA_BITS-1:0]  frame_code;

  // frame checks
  logic stop_ok;
  logic parity_ok;
  logic frame_ok;

  // the current edge takes the stop bit
  logic last_bit;

  // last good code was the release prefix
  logic break_armed;

  // stop bit is still on the line, it never enters the shift register
  assign frame_w    = {kbd_data, shift_q};
  assign frame_code = frame_w[KBD_START_POS+1 +: KBD_DATA_BITS];

  assign last_bit = (bit_cnt == 4'(KBD_FRAME_BITS - 1));

  // start bit is known to be 0 since counting began on it
  assign stop_ok   = (frame_w[KBD_STOP_POS] == 1'b1);
  // odd parity over data and parity bit
  assign parity_ok = ^{frame_w[KBD_PARITY_POS], frame_code};
  assign frame_ok  = stop_ok && parity_ok;

  // frame sequencing and result flags
  always_ff @(negedge kbd_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt        <= 4'd0;
      code_valid     <= 1'b0;
      frame_error_kc <= 1'b0;
      break_armed    <= 1'b0;
    end else begin
      // release strobe lasts a single kbd_clk period
      code_valid <= 1'b0;

      if (bit_cnt == 4'd0) begin
        // a low level on an idle line is a start bit
        if (!kbd_data) begin
          bit_cnt <= 4'd1;
        end
      end else if (last_bit) begin
        bit_cnt <= 4'd0;

        // error level holds until the next frame completes
        frame_error_kc <= !frame_ok;

        // only a clean frame right after F0 counts as a release
        code_valid <= frame_ok && break_armed;

        // a damaged frame also drops a pending prefix
        break_armed <= frame_ok && (frame_code == KBD_BREAK_CODE);
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

  // serial data path
  always_ff @(negedge kbd_clk) begin
    // shifting while idle is harmless, the start bit realigns the frame
    shift_q <= {kbd_data, shift_q[KBD_FRAME_BITS-2:1]};

    // code is held for the FIFO write that follows on the rising edge
    if (last_bit) begin
      code <= frame_code;
    end
  end

endmodule

`default_nettype wire

// ==== common/kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

  // ps/2 device to host frame
  // 1 start bit, 8 data bits lsb first, 1 odd parity bit, 1 stop bit
  localparam int unsigned KBD_FRAME_BITS = 11;

  // width of one scan code
  localparam int unsigned KBD_DATA_BITS = 8;

  // release prefix sent ahead of the scan code of a released key
  localparam logic [KBD_DATA_BITS-1:0] KBD_BREAK_CODE = 8'hF0;

  // bit positions inside a received frame
  // the first bit on the line lands at position 0
  localparam int unsigned KBD_START_POS = 0;

  // data occupies the positions between start and parity
  localparam int unsigned KBD_PARITY_POS = KBD_START_POS + KBD_DATA_BITS + 1;

  // stop bit is the last one on the line
  localparam int unsigned KBD_STOP_POS = KBD_PARITY_POS + 1;

endpackage

`default_nettype wire
